// File: hdl/irq_pkg.sv
// shared sizes, CSR map and sequencer state type for the interrupt controller
// referenced by scoped names from every RTL file of the controller

package irq_pkg;

    //************************************************************************
    // sizes
    //************************************************************************
    localparam int NUM_LANES = 4;              // thread lanes per CSR port
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;
    localparam int NUM_REGS  = 16;             // slots behind the low address bits
    localparam int NUM_GP    = 8;              // general words R0..R7
    localparam int IDX_W     = $clog2(NUM_REGS);
    localparam int LANE_W    = $clog2(NUM_LANES);

    typedef logic [IDX_W-1:0]  reg_idx_t;
    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [DATA_W-1:0] csr_word_t;

    // one word per thread lane, lane 0 in the low bits
    typedef csr_word_t [NUM_LANES-1:0] lane_data_t;

    //************************************************************************
    // CSR map
    //************************************************************************
    // upper address bits select the block, the low IDX_W bits pick the slot
    localparam logic [ADDR_W-1:0] CSR_BASE = 12'h7C0;

    localparam reg_idx_t IDX_S2V = 4'd0;       // scalar to SIMT request
    localparam reg_idx_t IDX_V2S = 4'd1;
    localparam reg_idx_t IDX_TID = 4'd2;
    localparam reg_idx_t IDX_IPC = 4'd3;       // interrupted pc
    localparam reg_idx_t IDX_IRQ = 4'd4;
    localparam reg_idx_t IDX_ACC = 4'd5;
    localparam reg_idx_t IDX_ERR = 4'd6;
    // slot 7 is a hole in the map
    localparam reg_idx_t IDX_R0  = 4'd8;       // general words run up to slot 15

    //************************************************************************
    // handoff sequencer
    //************************************************************************
    typedef enum logic [2:0] {
        IRQC_IDLE,
        IRQC_WAIT,        // warp masked, waiting for the pipe to drain
        IRQC_PC_SWAP,
        IRQC_WAIT_ISR,
        IRQC_REVERT
    } irq_state_t;

endpackage

// File: hdl/irq_csr_port.sv
// CSR access decode for one core, combinational
// turns the bus into a slot index plus the word of the lowest active write lane

`timescale 1ns/10ps

module irq_csr_port (
    input  logic                           read_enable,
    input  logic                           write_enable,
    input  logic [irq_pkg::ADDR_W-1:0]     read_addr,
    input  logic [irq_pkg::ADDR_W-1:0]     write_addr,
    input  logic [irq_pkg::NUM_LANES-1:0]  write_tmask,
    input  irq_pkg::lane_data_t            write_data,
    output logic                           rd_hit,
    output irq_pkg::reg_idx_t              rd_idx,
    output logic                           wr_stb,
    output irq_pkg::reg_idx_t              wr_idx,
    output irq_pkg::csr_word_t             wr_word
);

    logic [irq_pkg::ADDR_W-1:0] acc_addr;
    irq_pkg::reg_idx_t          slot;
    logic                       base_match;
    logic                       slot_mapped;
    irq_pkg::lane_t             wr_lane;

    // a write takes the bus address over a read in the same cycle
    assign acc_addr = write_enable ? write_addr : read_addr;
    assign slot     = acc_addr[irq_pkg::IDX_W-1:0];

    assign base_match = (acc_addr[irq_pkg::ADDR_W-1:irq_pkg::IDX_W] ==
                         irq_pkg::CSR_BASE[irq_pkg::ADDR_W-1:irq_pkg::IDX_W]);
    assign slot_mapped = (slot <= irq_pkg::IDX_ERR) || (slot >= irq_pkg::IDX_R0);

    // lowest set mask bit wins, empty mask falls back to lane 0
    always_comb
    begin
        wr_lane = '0;
        for (int i = irq_pkg::NUM_LANES - 1; i >= 0; i--)
        begin
            if (write_tmask[i])
                wr_lane = irq_pkg::lane_t'(i);
        end
    end

    assign rd_hit  = read_enable && base_match && slot_mapped;
    assign rd_idx  = slot;
    assign wr_stb  = write_enable && base_match && slot_mapped;
    assign wr_idx  = slot;
    assign wr_word = write_data[wr_lane];

endmodule

// File: hdl/irq_reg_file.sv
// controller register block shared by the SIMT and scalar CSR ports
// SIMT writes lose to scalar writes, and both lose to sequencer updates

`timescale 1ns/10ps

module irq_reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 simt_rd_hit,
    input  irq_pkg::reg_idx_t    simt_rd_idx,
    input  logic                 simt_wr_stb,
    input  irq_pkg::reg_idx_t    simt_wr_idx,
    input  irq_pkg::csr_word_t   simt_wr_word,
    input  logic                 scalar_rd_hit,
    input  irq_pkg::reg_idx_t    scalar_rd_idx,
    input  logic                 scalar_wr_stb,
    input  irq_pkg::reg_idx_t    scalar_wr_idx,
    input  irq_pkg::csr_word_t   scalar_wr_word,
    input  logic                 err_set,
    input  logic                 err_clear,
    input  logic                 s2v_clear,
    input  logic                 ipc_load,
    input  irq_pkg::csr_word_t   pc,
    output irq_pkg::lane_data_t  simt_read_data,
    output irq_pkg::lane_data_t  scalar_read_data,
    output irq_pkg::csr_word_t   s2v
);

    irq_pkg::csr_word_t s2v_q, v2s_q, tid_q, ipc_q, irq_q, acc_q, err_q;
    irq_pkg::csr_word_t gp_q   [irq_pkg::NUM_GP];
    irq_pkg::csr_word_t slot_q [irq_pkg::NUM_REGS];   // slot view of the words
    irq_pkg::csr_word_t slot_d [irq_pkg::NUM_REGS];

    always_comb
    begin
        slot_q = '{default: '0};                      // hole at slot 7 reads zero
        slot_q[irq_pkg::IDX_S2V] = s2v_q;
        slot_q[irq_pkg::IDX_V2S] = v2s_q;
        slot_q[irq_pkg::IDX_TID] = tid_q;
        slot_q[irq_pkg::IDX_IPC] = ipc_q;
        slot_q[irq_pkg::IDX_IRQ] = irq_q;
        slot_q[irq_pkg::IDX_ACC] = acc_q;
        slot_q[irq_pkg::IDX_ERR] = err_q;
        for (int g = 0; g < irq_pkg::NUM_GP; g++)
            slot_q[irq_pkg::reg_idx_t'(irq_pkg::IDX_R0 + g)] = gp_q[g];
    end

    // later assignments take priority
    always_comb
    begin
        slot_d = slot_q;
        if (simt_wr_stb)
            slot_d[simt_wr_idx] = simt_wr_word;
        if (scalar_wr_stb)
            slot_d[scalar_wr_idx] = scalar_wr_word;
        if (ipc_load)
            slot_d[irq_pkg::IDX_IPC] = pc;            // interrupted pc of the thread
        if (err_clear)
            slot_d[irq_pkg::IDX_ERR] = '0;
        if (err_set)
            slot_d[irq_pkg::IDX_ERR] = irq_pkg::csr_word_t'(1);
        if (s2v_clear)
            slot_d[irq_pkg::IDX_S2V] = '0;            // ack of a failed request
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s2v_q <= '0;
            v2s_q <= '0;
            tid_q <= '0;
            ipc_q <= '0;
            irq_q <= '0;
            acc_q <= '0;
            err_q <= '0;
            for (int g = 0; g < irq_pkg::NUM_GP; g++)
                gp_q[g] <= '0;
        end
        else
        begin
            s2v_q <= slot_d[irq_pkg::IDX_S2V];
            v2s_q <= slot_d[irq_pkg::IDX_V2S];
            tid_q <= slot_d[irq_pkg::IDX_TID];
            ipc_q <= slot_d[irq_pkg::IDX_IPC];
            irq_q <= slot_d[irq_pkg::IDX_IRQ];
            acc_q <= slot_d[irq_pkg::IDX_ACC];
            err_q <= slot_d[irq_pkg::IDX_ERR];
            for (int g = 0; g < irq_pkg::NUM_GP; g++)
                gp_q[g] <= slot_d[irq_pkg::reg_idx_t'(irq_pkg::IDX_R0 + g)];
        end
    end

    // same word on every lane
    assign simt_read_data   = simt_rd_hit ?
                              {irq_pkg::NUM_LANES{slot_q[simt_rd_idx]}} : '0;
    assign scalar_read_data = scalar_rd_hit ?
                              {irq_pkg::NUM_LANES{slot_q[scalar_rd_idx]}} : '0;
    assign s2v = s2v_q;

endmodule

// File: hdl/irq_sequencer.sv
// handoff FSM moving one SIMT thread over to the scalar core
// drives the SIMT core controls and asks the register block for ERR, S2V and IPC updates

`timescale 1ns/10ps

module irq_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  irq_pkg::csr_word_t  s2v,
    input  logic                pipe_clean,
    input  logic                err,
    output logic                mask_warp,
    output logic                hw_int,
    output logic                mask_threads,
    output logic                swap_pc,
    output logic                err_set,
    output logic                err_clear,
    output logic                s2v_clear,
    output logic                ipc_load
);

    irq_pkg::irq_state_t state_q, state_d;
    logic                req_pending;

    assign req_pending = (s2v == irq_pkg::csr_word_t'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= irq_pkg::IRQC_IDLE;
        else
            state_q <= state_d;
    end

    //************************************************************************
    // next state
    //************************************************************************
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            irq_pkg::IRQC_IDLE:
                if (req_pending)
                    state_d = irq_pkg::IRQC_WAIT;
            irq_pkg::IRQC_WAIT:
            begin
                if (err)
                    state_d = irq_pkg::IRQC_IDLE;     // request refused by the core
                else if (pipe_clean)
                    state_d = irq_pkg::IRQC_PC_SWAP;
            end
            irq_pkg::IRQC_PC_SWAP:
                state_d = irq_pkg::IRQC_WAIT_ISR;
            irq_pkg::IRQC_WAIT_ISR:
                if (s2v == '0)                        // scalar side done
                    state_d = irq_pkg::IRQC_REVERT;
            default:
                state_d = irq_pkg::IRQC_IDLE;
        endcase
    end

    // core controls straight from the state
    assign mask_warp    = (state_q == irq_pkg::IRQC_WAIT);
    assign hw_int       = (state_q == irq_pkg::IRQC_WAIT) ||
                          (state_q == irq_pkg::IRQC_PC_SWAP) ||
                          (state_q == irq_pkg::IRQC_WAIT_ISR);
    assign mask_threads = (state_q == irq_pkg::IRQC_PC_SWAP) ||
                          (state_q == irq_pkg::IRQC_WAIT_ISR);
    assign swap_pc      = (state_q == irq_pkg::IRQC_PC_SWAP);

    // register updates land on the edge of the matching transition
    assign err_clear = (state_q == irq_pkg::IRQC_IDLE) && req_pending;
    assign err_set   = (state_q == irq_pkg::IRQC_WAIT) && err;
    assign s2v_clear = (state_q == irq_pkg::IRQC_WAIT) && err;
    assign ipc_load  = (state_q == irq_pkg::IRQC_PC_SWAP);

endmodule

// File: hdl/irq_ctl_top.sv
// top of the SIMT to scalar interrupt controller
// two CSR port decoders in front of one register block, plus the handoff FSM

`timescale 1ns/10ps

module irq_ctl_top (
    input  logic                           clk,
    input  logic                           reset,
    // SIMT core CSR bus
    input  logic                           simt_read_enable,
    input  logic [irq_pkg::ADDR_W-1:0]     simt_read_addr,
    input  logic                           simt_write_enable,
    input  logic [irq_pkg::ADDR_W-1:0]     simt_write_addr,
    input  logic [irq_pkg::NUM_LANES-1:0]  simt_write_tmask,
    input  irq_pkg::lane_data_t            simt_write_data,
    output irq_pkg::lane_data_t            simt_read_data,
    // scalar core CSR bus
    input  logic                           scalar_read_enable,
    input  logic [irq_pkg::ADDR_W-1:0]     scalar_read_addr,
    input  logic                           scalar_write_enable,
    input  logic [irq_pkg::ADDR_W-1:0]     scalar_write_addr,
    input  logic [irq_pkg::NUM_LANES-1:0]  scalar_write_tmask,
    input  irq_pkg::lane_data_t            scalar_write_data,
    output irq_pkg::lane_data_t            scalar_read_data,
    // SIMT core side
    input  logic                           pipe_clean,
    input  logic                           err,
    input  irq_pkg::csr_word_t             pc,
    output logic                           mask_warp,
    output logic                           hw_int,
    output logic                           mask_threads,
    output logic                           swap_pc
);

    logic               simt_rd_hit, simt_wr_stb, scalar_rd_hit, scalar_wr_stb;
    irq_pkg::reg_idx_t  simt_rd_idx, simt_wr_idx, scalar_rd_idx, scalar_wr_idx;
    irq_pkg::csr_word_t simt_wr_word, scalar_wr_word, s2v;
    logic               err_set, err_clear, s2v_clear, ipc_load;

    irq_csr_port simt_port (
        .read_enable (simt_read_enable),  .write_enable (simt_write_enable),
        .read_addr   (simt_read_addr),    .write_addr   (simt_write_addr),
        .write_tmask (simt_write_tmask),  .write_data   (simt_write_data),
        .rd_hit      (simt_rd_hit),       .rd_idx       (simt_rd_idx),
        .wr_stb      (simt_wr_stb),       .wr_idx       (simt_wr_idx),
        .wr_word     (simt_wr_word)
    );

    irq_csr_port scalar_port (
        .read_enable (scalar_read_enable), .write_enable (scalar_write_enable),
        .read_addr   (scalar_read_addr),   .write_addr   (scalar_write_addr),
        .write_tmask (scalar_write_tmask), .write_data   (scalar_write_data),
        .rd_hit      (scalar_rd_hit),      .rd_idx       (scalar_rd_idx),
        .wr_stb      (scalar_wr_stb),      .wr_idx       (scalar_wr_idx),
        .wr_word     (scalar_wr_word)
    );

    irq_reg_file reg_file (
        .clk            (clk),            .reset          (reset),
        .simt_rd_hit    (simt_rd_hit),    .simt_rd_idx    (simt_rd_idx),
        .simt_wr_stb    (simt_wr_stb),    .simt_wr_idx    (simt_wr_idx),
        .simt_wr_word   (simt_wr_word),
        .scalar_rd_hit  (scalar_rd_hit),  .scalar_rd_idx  (scalar_rd_idx),
        .scalar_wr_stb  (scalar_wr_stb),  .scalar_wr_idx  (scalar_wr_idx),
        .scalar_wr_word (scalar_wr_word),
        .err_set        (err_set),        .err_clear      (err_clear),
        .s2v_clear      (s2v_clear),      .ipc_load       (ipc_load),
        .pc             (pc),
        .simt_read_data (simt_read_data), .scalar_read_data (scalar_read_data),
        .s2v            (s2v)
    );

    irq_sequencer sequencer (
        .clk          (clk),          .reset     (reset),
        .s2v          (s2v),          .pipe_clean (pipe_clean),
        .err          (err),
        .mask_warp    (mask_warp),    .hw_int    (hw_int),
        .mask_threads (mask_threads), .swap_pc   (swap_pc),
        .err_set      (err_set),      .err_clear (err_clear),
        .s2v_clear    (s2v_clear),    .ipc_load  (ipc_load)
    );

endmodule

// File: include/irq_ctl_tests.svh
// directed tests of the interrupt controller, included inside the testbench module
// each task drives the CSR buses and core inputs and checks what comes back

task automatic test_reset_values();
    @(negedge clk);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0);
    for (int s = 0; s < irq_pkg::NUM_REGS; s++)
    begin
        if (s != 7)                                    // slot 7 is the hole
        begin
            check_read(1'b0, csr_addr(irq_pkg::reg_idx_t'(s)), '0, "simt_read_data");
            check_read(1'b1, csr_addr(irq_pkg::reg_idx_t'(s)), '0, "scalar_read_data");
        end
    end
endtask

task automatic test_write_readback(input logic on_scalar);
    logic [irq_pkg::NUM_LANES-1:0] masks [5] = '{4'b0001, 4'b0110, 4'b1100, 4'b1000, 4'b0000};
    irq_pkg::reg_idx_t slots [5] = '{irq_pkg::IDX_V2S, irq_pkg::IDX_ACC, irq_pkg::IDX_R0,
                                     4'd11, 4'd15};
    irq_pkg::lane_data_t data;
    string rd_name;
    rd_name = on_scalar ? "scalar_read_data" : "simt_read_data";
    for (int k = 0; k < 5; k++)
    begin
        data = random_lanes();
        bus_write(on_scalar, csr_addr(slots[k]), masks[k], data);
        check_read(on_scalar, csr_addr(slots[k]), lowest_lane_word(masks[k], data), rd_name);
    end
    // address still points at a loaded word
    @(posedge clk);
    simt_read_enable   <= 1'b0;
    scalar_read_enable <= 1'b0;
    @(negedge clk);
    check_lanes(rd_name, '0, on_scalar ? scalar_read_data : simt_read_data);
endtask

task automatic test_unmapped();
    irq_pkg::lane_data_t data;
    data = random_lanes();
    bus_write(1'b1, csr_addr(irq_pkg::IDX_R0), 4'b0001, data);
    bus_write(1'b1, csr_addr(4'd7), 4'b0001, random_lanes());
    bus_write(1'b0, 12'h6C8, 4'b0001, random_lanes());    // R0 slot under a wrong base
    check_read(1'b1, csr_addr(4'd7), '0, "scalar_read_data");
    check_read(1'b0, 12'h6C8, '0, "simt_read_data");
    check_read(1'b0, csr_addr(irq_pkg::IDX_R0), data[0], "simt_read_data");
    check_read(1'b1, csr_addr(irq_pkg::IDX_ERR), '0, "scalar_read_data");
endtask

task automatic test_same_cycle_write();
    irq_pkg::lane_data_t simt_data, scalar_data;
    simt_data   = random_lanes();
    scalar_data = random_lanes();
    @(posedge clk);
    simt_write_enable   <= 1'b1;
    simt_write_addr     <= csr_addr(irq_pkg::IDX_TID);
    simt_write_tmask    <= 4'b0010;
    simt_write_data     <= simt_data;
    scalar_write_enable <= 1'b1;
    scalar_write_addr   <= csr_addr(irq_pkg::IDX_TID);
    scalar_write_tmask  <= 4'b0100;
    scalar_write_data   <= scalar_data;
    @(posedge clk);
    simt_write_enable   <= 1'b0;
    scalar_write_enable <= 1'b0;
    check_read(1'b0, csr_addr(irq_pkg::IDX_TID), scalar_data[2], "simt_read_data");
endtask

task automatic test_handoff();
    irq_pkg::csr_word_t int_pc;
    int_pc = $random(seed);
    bus_write(1'b1, csr_addr(irq_pkg::IDX_S2V), 4'b0001, {irq_pkg::NUM_LANES{32'd1}});
    @(posedge clk);
    @(negedge clk);
    check_controls(1'b1, 1'b1, 1'b0, 1'b0);           // warp masked, waiting for the pipe
    @(posedge clk);
    pipe_clean <= 1'b1;
    pc         <= int_pc;
    @(posedge clk);
    pipe_clean <= 1'b0;
    @(negedge clk);
    check_controls(1'b0, 1'b1, 1'b1, 1'b1);
    check_read(1'b1, csr_addr(irq_pkg::IDX_IPC), int_pc, "scalar_read_data");
    check_controls(1'b0, 1'b1, 1'b1, 1'b0);           // swap_pc lasted one cycle
    bus_write(1'b1, csr_addr(irq_pkg::IDX_S2V), 4'b0001, '0);
    @(negedge clk);
    check_controls(1'b0, 1'b1, 1'b1, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic test_failed_handoff();
    bus_write(1'b1, csr_addr(irq_pkg::IDX_S2V), 4'b0001, {irq_pkg::NUM_LANES{32'd1}});
    @(posedge clk);
    @(negedge clk);
    check_controls(1'b1, 1'b1, 1'b0, 1'b0);
    @(posedge clk);
    err <= 1'b1;
    @(posedge clk);
    err <= 1'b0;
    @(negedge clk);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0);
    check_read(1'b1, csr_addr(irq_pkg::IDX_ERR), 32'd1, "scalar_read_data");
    check_read(1'b1, csr_addr(irq_pkg::IDX_S2V), '0, "scalar_read_data");
    // a fresh request clears the error word again
    bus_write(1'b1, csr_addr(irq_pkg::IDX_S2V), 4'b0001, {irq_pkg::NUM_LANES{32'd1}});
    @(posedge clk);
    @(negedge clk);
    check_bit("hw_int", 1'b1, hw_int);
    check_read(1'b0, csr_addr(irq_pkg::IDX_ERR), '0, "simt_read_data");
endtask

// File: verif/irq_ctl_tb.sv
// testbench for the SIMT to scalar interrupt controller
// bus driver and compare tasks live here, the directed tests come from irq_ctl_tests.svh

`timescale 1ns/10ps

module irq_ctl_tb;

    localparam int CLK_NS     = 40;
    localparam int MAX_CYCLES = 2000;                 // tests finish in about 300

    logic clk = 1'b0;
    logic reset;
    logic                           simt_read_enable, simt_write_enable;
    logic [irq_pkg::ADDR_W-1:0]     simt_read_addr, simt_write_addr;
    logic [irq_pkg::NUM_LANES-1:0]  simt_write_tmask;
    irq_pkg::lane_data_t            simt_write_data, simt_read_data;
    logic                           scalar_read_enable, scalar_write_enable;
    logic [irq_pkg::ADDR_W-1:0]     scalar_read_addr, scalar_write_addr;
    logic [irq_pkg::NUM_LANES-1:0]  scalar_write_tmask;
    irq_pkg::lane_data_t            scalar_write_data, scalar_read_data;
    logic                           pipe_clean, err;
    irq_pkg::csr_word_t             pc;
    logic                           mask_warp, hw_int, mask_threads, swap_pc;
    integer                         seed = 32'h143e;

    always #(CLK_NS / 2) clk = ~clk;

    irq_ctl_top irq_ctl_top_i (.*);

    //************************************************************************
    // compare tasks
    //************************************************************************
    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input irq_pkg::csr_word_t expected,
                              input irq_pkg::csr_word_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_lanes(input string name, input irq_pkg::lane_data_t expected,
                               input irq_pkg::lane_data_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_controls(input logic exp_mw, input logic exp_hi,
                                  input logic exp_mt, input logic exp_sp);
        check_bit("mask_warp", exp_mw, mask_warp);
        check_bit("hw_int", exp_hi, hw_int);
        check_bit("mask_threads", exp_mt, mask_threads);
        check_bit("swap_pc", exp_sp, swap_pc);
    endtask

    //************************************************************************
    // bus drivers and stimulus helpers
    //************************************************************************
    function automatic logic [irq_pkg::ADDR_W-1:0] csr_addr(input irq_pkg::reg_idx_t idx);
        return {irq_pkg::CSR_BASE[irq_pkg::ADDR_W-1:irq_pkg::IDX_W], idx};
    endfunction

    // lane picked by the lowest set mask bit, lane 0 for an empty mask
    function automatic irq_pkg::csr_word_t lowest_lane_word(
        input logic [irq_pkg::NUM_LANES-1:0] tmask, input irq_pkg::lane_data_t data);
        if (tmask[0] || tmask == '0)
            return data[0];
        else if (tmask[1])
            return data[1];
        else if (tmask[2])
            return data[2];
        return data[3];
    endfunction

    function automatic irq_pkg::lane_data_t random_lanes();
        irq_pkg::lane_data_t d;
        for (int i = 0; i < irq_pkg::NUM_LANES; i++)
            d[i] = $random(seed);
        return d;
    endfunction

    task automatic bus_write(input logic on_scalar, input logic [irq_pkg::ADDR_W-1:0] addr,
                             input logic [irq_pkg::NUM_LANES-1:0] tmask,
                             input irq_pkg::lane_data_t data);
        @(posedge clk);
        simt_read_enable   <= 1'b0;
        scalar_read_enable <= 1'b0;
        if (on_scalar)
        begin
            scalar_write_enable <= 1'b1;
            scalar_write_addr   <= addr;
            scalar_write_tmask  <= tmask;
            scalar_write_data   <= data;
        end
        else
        begin
            simt_write_enable <= 1'b1;
            simt_write_addr   <= addr;
            simt_write_tmask  <= tmask;
            simt_write_data   <= data;
        end
        @(posedge clk);                                // write lands on this edge
        simt_write_enable   <= 1'b0;
        scalar_write_enable <= 1'b0;
    endtask

    task automatic check_read(input logic on_scalar, input logic [irq_pkg::ADDR_W-1:0] addr,
                              input irq_pkg::csr_word_t expected, input string name);
        irq_pkg::lane_data_t data;
        @(posedge clk);
        if (on_scalar)
        begin
            scalar_read_enable <= 1'b1;
            scalar_read_addr   <= addr;
        end
        else
        begin
            simt_read_enable <= 1'b1;
            simt_read_addr   <= addr;
        end
        @(negedge clk);
        data = on_scalar ? scalar_read_data : simt_read_data;
        // every lane carries the addressed word
        for (int i = 0; i < irq_pkg::NUM_LANES; i++)
            check_word($sformatf("%s[%0d]", name, i), expected, data[i]);
    endtask

    `include "irq_ctl_tests.svh"

    initial
    begin
        reset               <= 1'b1;
        simt_read_enable    <= 1'b0;
        simt_write_enable   <= 1'b0;
        simt_read_addr      <= '0;
        simt_write_addr     <= '0;
        simt_write_tmask    <= '0;
        simt_write_data     <= '0;
        scalar_read_enable  <= 1'b0;
        scalar_write_enable <= 1'b0;
        scalar_read_addr    <= '0;
        scalar_write_addr   <= '0;
        scalar_write_tmask  <= '0;
        scalar_write_data   <= '0;
        pipe_clean          <= 1'b0;
        err                 <= 1'b0;
        pc                  <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_reset_values();
        test_write_readback(1'b0);
        test_write_readback(1'b1);
        test_unmapped();
        test_same_cycle_write();
        test_handoff();
        test_failed_handoff();

        $display("PASS: all tests");
        $finish;
    end

    initial
    begin
        #(MAX_CYCLES * CLK_NS);
        $display("watchdog expired after %0d cycles, the tests did not finish", MAX_CYCLES);
        stop_on_failure();
    end

endmodule

// File: src.f
+incdir+include
hdl/irq_pkg.sv
hdl/irq_csr_port.sv
hdl/irq_reg_file.sv
hdl/irq_sequencer.sv
hdl/irq_ctl_top.sv
verif/irq_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Mdir obj_dir -o irq_ctl_sim \
    --top-module irq_ctl_tb -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/irq_ctl_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
